/* Bender.yml */
package:
  name: hps_link

sources:
  - logic/hps_link_pkg.sv
  - logic/conf_rom.sv
  - logic/uio_decoder.sv
  - logic/ps2_key_decoder.sv
  - logic/file_loader.sv
  - logic/hps_link.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/hps_link_tb.sv

/* logic/conf_rom.sv */
`timescale 1ns/1ns

module conf_rom import hps_link_pkg::*; (
	input  logic             clk_sys,
	input  logic [CNT_W-1:0] conf_addr,
	output io_byte_t         conf_byte
);

	io_byte_t rom [2**CNT_W];

	// unpack the string, first character at address 0
	// entries past the end read as zero
	initial begin
		for (int i = 0; i < 2**CNT_W; i++) begin
			if (i < CONF_LEN) begin
				rom[i] = CONF_STR[(CONF_LEN - i) * 8 - 1 -: 8];
			end else begin
				rom[i] = '0;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		conf_byte <= rom[conf_addr];
	end

endmodule

/* logic/file_loader.sv */
`timescale 1ns/1ns

module file_loader import hps_link_pkg::*; (
	input  logic     clk_sys,
	input  logic     rst_n,
	input  logic     io_strobe,
	input  logic     fp_enable,
	input  word_t    io_din,
	output logic     ioctl_download,
	output word_t    ioctl_index,
	output logic     ioctl_wr,
	output io_addr_t ioctl_addr,
	output io_byte_t ioctl_dout
);

	fio_cmd_e cmd;
	logic     has_cmd;
	logic     tx_first;
	logic     wr_pend;
	io_addr_t addr;

	////////////////////////////////////////
	// file frame decode
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cmd            <= fio_cmd_e'(16'h0000);
			has_cmd        <= 1'b0;
			tx_first       <= 1'b0;
			wr_pend        <= 1'b0;
			addr           <= '0;
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_wr       <= 1'b0;
			ioctl_addr     <= '0;
			ioctl_dout     <= '0;
		end else begin
			// write strobe trails the data latch by one cycle
			ioctl_wr <= wr_pend;
			wr_pend  <= 1'b0;

			if (!fp_enable) begin
				has_cmd <= 1'b0;
			end else if (io_strobe) begin
				if (!has_cmd) begin
					cmd      <= fio_cmd_e'(io_din);
					has_cmd  <= 1'b1;
					tx_first <= 1'b1;
				end else begin
					case (cmd)
						FIO_FILE_INDEX: ioctl_index <= io_din;

						// only the first data word starts or stops
						FIO_FILE_TX: begin
							tx_first <= 1'b0;
							if (tx_first) begin
								if (io_din[7:0] != 8'h00) begin
									addr           <= '0;
									ioctl_download <= 1'b1;
								end else begin
									ioctl_download <= 1'b0;
								end
							end
						end

						FIO_FILE_TX_DAT: begin
							if (ioctl_download) begin
								ioctl_addr <= addr;
								ioctl_dout <= io_din[7:0];
								wr_pend    <= 1'b1;
								addr       <= addr + 1'b1;
							end
						end

						default: ;
					endcase
				end
			end
		end
	end

	// no write may escape after the download has closed
	assert property (@(posedge clk_sys) disable iff (!rst_n)
		ioctl_wr |-> ioctl_download);

endmodule

/* logic/hps_link.sv */
`timescale 1ns/1ns

module hps_link import hps_link_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       io_strobe,
	input  logic       io_enable,
	input  logic       fp_enable,
	input  word_t      io_din,
	output word_t      io_dout,
	output logic [1:0] buttons,
	output logic       forced_scandoubler,
	output logic       direct_video,
	output joy_t       joystick_0,
	output joy_t       joystick_1,
	output joy_t       joystick_2,
	output joy_t       joystick_3,
	output status_t    status,
	output key_event_t ps2_key,
	output logic       ioctl_download,
	output word_t      ioctl_index,
	output logic       ioctl_wr,
	output io_addr_t   ioctl_addr,
	output io_byte_t   ioctl_dout
);

	logic [CNT_W-1:0] conf_addr;
	io_byte_t         conf_byte;
	word_t            kbd_word;
	logic             kbd_valid;
	logic             kbd_clear;
	logic             kbd_done;

	////////////////////////////////////////
	// user-I/O side
	////////////////////////////////////////

	uio_decoder u_uio_decoder (
		.clk_sys            (clk_sys),
		.rst_n              (rst_n),
		.io_strobe          (io_strobe),
		.io_enable          (io_enable),
		.io_din             (io_din),
		.conf_byte          (conf_byte),
		.io_dout            (io_dout),
		.conf_addr          (conf_addr),
		.kbd_word           (kbd_word),
		.kbd_valid          (kbd_valid),
		.kbd_clear          (kbd_clear),
		.kbd_done           (kbd_done),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.joystick_2         (joystick_2),
		.joystick_3         (joystick_3),
		.status             (status)
	);

	conf_rom u_conf_rom (
		.clk_sys   (clk_sys),
		.conf_addr (conf_addr),
		.conf_byte (conf_byte)
	);

	ps2_key_decoder u_ps2_key_decoder (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.kbd_word  (kbd_word),
		.kbd_valid (kbd_valid),
		.kbd_clear (kbd_clear),
		.kbd_done  (kbd_done),
		.ps2_key   (ps2_key)
	);

	////////////////////////////////////////
	// file transfer side
	////////////////////////////////////////

	file_loader u_file_loader (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.io_strobe      (io_strobe),
		.fp_enable      (fp_enable),
		.io_din         (io_din),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

endmodule

/* logic/hps_link_pkg.sv */
package hps_link_pkg;

	////////////////////////////////////////
	// bus and payload types
	////////////////////////////////////////

	// one word on io_din / io_dout
	typedef logic [15:0]  word_t;

	// digital joystick buttons
	typedef logic [31:0]  joy_t;

	// core status, sent as 16-bit slices
	typedef logic [127:0] status_t;

	// [7:0] code, [8] extended, [9] pressed, [10] toggle
	typedef logic [10:0]  key_event_t;

	// file download stream
	typedef logic [7:0]   io_byte_t;
	typedef logic [26:0]  io_addr_t;

	////////////////////////////////////////
	// command codes
	////////////////////////////////////////

	// user-I/O frame, first word
	typedef enum logic [15:0] {
		CMD_CFG      = 16'h0001,
		CMD_JOY0     = 16'h0002,
		CMD_JOY1     = 16'h0003,
		CMD_KBD      = 16'h0005,
		CMD_JOY2     = 16'h0010,
		CMD_JOY3     = 16'h0011,
		CMD_CONF_STR = 16'h0014,
		CMD_STATUS   = 16'h001E
	} uio_cmd_e;

	// file frame, first word
	typedef enum logic [15:0] {
		FIO_FILE_TX     = 16'h0053,
		FIO_FILE_TX_DAT = 16'h0054,
		FIO_FILE_INDEX  = 16'h0055
	} fio_cmd_e;

	////////////////////////////////////////
	// core configuration string
	////////////////////////////////////////

	// packed bytes, first character in the top byte
	localparam CONF_STR = "HPSLINK;;F1,BIN,Load ROM;O12,Scale,Off,2x;R0,Reset;V,v1";

	// character count, must stay below the counter limit
	localparam int CONF_LEN = $bits(CONF_STR) / 8;

	// word counter width, counter sticks at all ones
	localparam int CNT_W = 6;

	// 16-bit slices in the status word
	localparam int STATUS_WORDS = 8;

endpackage

/* logic/ps2_key_decoder.sv */
`timescale 1ns/1ns

module ps2_key_decoder import hps_link_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  word_t      kbd_word,
	input  logic       kbd_valid,
	input  logic       kbd_clear,
	input  logic       kbd_done,
	output key_event_t ps2_key
);

	logic [31:0] raw;
	logic        skip;
	logic        pressed;
	logic        extended;
	logic [9:0]  key_next;

	// F0 just before the code marks a release
	assign pressed  = (raw[15:8] != 8'hf0);
	assign extended = pressed ? (raw[15:8] == 8'he0) : (raw[23:16] == 8'he0);

	////////////////////////////////////////
	// event code, long sequences first
	////////////////////////////////////////

	always_comb begin
		case (raw)
			// print screen press
			32'he012e07c: key_next = 10'h37c;
			// print screen release
			32'h7ce0f012: key_next = 10'h17c;
			// pause, press only
			32'hf014f077: key_next = 10'h377;
			default:      key_next = {pressed, extended, raw[7:0]};
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			raw     <= '0;
			skip    <= 1'b0;
			ps2_key <= '0;
		end else begin
			if (kbd_clear) begin
				raw  <= '0;
				skip <= 1'b0;
			end else if (kbd_valid) begin
				// upper byte all ones drops the whole frame
				if (&kbd_word[15:8]) begin
					skip <= 1'b1;
				end else if (!skip) begin
					raw <= {raw[23:0], kbd_word[7:0]};
				end
			end

			if (kbd_done && !skip) begin
				ps2_key <= {~ps2_key[10], key_next};
			end
		end
	end

endmodule

/* logic/uio_decoder.sv */
`timescale 1ns/1ns

module uio_decoder import hps_link_pkg::*; (
	input  logic             clk_sys,
	input  logic             rst_n,
	input  logic             io_strobe,
	input  logic             io_enable,
	input  word_t            io_din,
	input  io_byte_t         conf_byte,
	output word_t            io_dout,
	output logic [CNT_W-1:0] conf_addr,
	output word_t            kbd_word,
	output logic             kbd_valid,
	output logic             kbd_clear,
	output logic             kbd_done,
	output logic [1:0]       buttons,
	output logic             forced_scandoubler,
	output logic             direct_video,
	output joy_t             joystick_0,
	output joy_t             joystick_1,
	output joy_t             joystick_2,
	output joy_t             joystick_3,
	output status_t          status
);

	uio_cmd_e                          cmd;
	logic [CNT_W-1:0]                  word_cnt;
	logic [CNT_W-1:0]                  word_idx;
	logic [$clog2(STATUS_WORDS)-1:0]   slice_idx;
	logic                              low_half;
	logic                              data_strobe;

	// data word n maps to index n-1 (rom address, status slice)
	assign word_idx    = word_cnt - 1'b1;
	assign conf_addr   = word_idx;
	assign slice_idx   = word_idx[$clog2(STATUS_WORDS)-1:0];
	assign low_half    = (word_cnt == CNT_W'(1));
	assign data_strobe = io_enable && io_strobe && (word_cnt != '0);

	////////////////////////////////////////
	// framing and register writes
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cmd                <= uio_cmd_e'(16'h0000);
			word_cnt           <= '0;
			io_dout            <= '0;
			kbd_valid          <= 1'b0;
			kbd_clear          <= 1'b0;
			kbd_done           <= 1'b0;
			buttons            <= '0;
			forced_scandoubler <= 1'b0;
			direct_video       <= 1'b0;
			joystick_0         <= '0;
			joystick_1         <= '0;
			joystick_2         <= '0;
			joystick_3         <= '0;
			status             <= '0;
		end else begin
			kbd_valid <= 1'b0;
			kbd_clear <= 1'b0;
			kbd_done  <= 1'b0;

			if (!io_enable) begin
				// frame closed so a keyboard event completes here
				kbd_done <= (cmd == CMD_KBD);
				cmd      <= uio_cmd_e'(16'h0000);
				word_cnt <= '0;
				io_dout  <= '0;
			end else if (io_strobe) begin
				io_dout <= '0;
				if (!(&word_cnt)) begin
					word_cnt <= word_cnt + 1'b1;
				end

				if (word_cnt == '0) begin
					cmd       <= uio_cmd_e'(io_din);
					kbd_clear <= (io_din == CMD_KBD);
				end else begin
					case (cmd)
						CMD_CFG: begin
							buttons            <= io_din[1:0];
							forced_scandoubler <= io_din[4];
							direct_video       <= io_din[10];
						end

						// word 1 low half, all later words high half
						CMD_JOY0: begin
							if (low_half) begin
								joystick_0[15:0] <= io_din;
							end else begin
								joystick_0[31:16] <= io_din;
							end
						end
						CMD_JOY1: begin
							if (low_half) begin
								joystick_1[15:0] <= io_din;
							end else begin
								joystick_1[31:16] <= io_din;
							end
						end
						CMD_JOY2: begin
							if (low_half) begin
								joystick_2[15:0] <= io_din;
							end else begin
								joystick_2[31:16] <= io_din;
							end
						end
						CMD_JOY3: begin
							if (low_half) begin
								joystick_3[15:0] <= io_din;
							end else begin
								joystick_3[31:16] <= io_din;
							end
						end

						// raw scan word goes to the key decoder
						CMD_KBD: kbd_valid <= 1'b1;

						// rom byte was fetched for this word already
						CMD_CONF_STR: begin
							if (word_cnt <= CONF_LEN) begin
								io_dout <= {8'h00, conf_byte};
							end
						end

						CMD_STATUS: begin
							if (word_cnt <= STATUS_WORDS) begin
								status[{slice_idx, 4'b0000} +: 16] <= io_din;
							end
						end

						default: ;
					endcase
				end
			end
		end
	end

	// raw scan word for the key decoder
	always_ff @(posedge clk_sys) begin
		if (data_strobe && (cmd == CMD_KBD)) begin
			kbd_word <= io_din;
		end
	end

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	// read-back data only inside a string frame
	assert property (@(posedge clk_sys) disable iff (!rst_n)
		(io_dout != '0) |-> ($past(io_enable) && (cmd == CMD_CONF_STR)));

	// key event only fires between frames
	assert property (@(posedge clk_sys) disable iff (!rst_n)
		kbd_done |-> !io_enable);

endmodule

/* testbench/hps_link_ref.svh */
`ifndef HPS_LINK_REF_SVH
`define HPS_LINK_REF_SVH

////////////////////////////////////////
// reference model
////////////////////////////////////////

// {direct video, forced scandoubler, buttons}
function automatic logic [3:0] cfg_ref(input word_t w);
	return {w[10], w[4], w[1:0]};
endfunction

// first data word is the low half, any later one the high half
function automatic joy_t joy_ref(input joy_t prev, input word_t w, input int word_no);
	joy_t j;
	j = prev;
	if (word_no == 1)
		j[15:0] = w;
	else
		j[31:16] = w;
	return j;
endfunction

function automatic status_t status_ref(input status_t prev, input word_t w, input int word_no);
	status_t s;
	s = prev;
	if (word_no >= 1 && word_no <= STATUS_WORDS)
		s[(word_no - 1) * 16 +: 16] = w;
	return s;
endfunction

// character i of the string, zero past the end
function automatic io_byte_t conf_char(input int i);
	if (i >= CONF_LEN)
		return 8'h00;
	return io_byte_t'(CONF_STR >> (8 * (CONF_LEN - 1 - i)));
endfunction

function automatic key_event_t key_ref(input logic [31:0] raw, input logic toggle);
	logic prs;
	logic ext;
	logic [9:0] ev;
	prs = (raw[15:8] != 8'hf0);
	if (prs)
		ext = (raw[15:8] == 8'he0);
	else
		ext = (raw[23:16] == 8'he0);
	ev = {prs, ext, raw[7:0]};
	// print screen and pause sequences
	if (raw == 32'he012e07c)
		ev = 10'h37c;
	if (raw == 32'h7ce0f012)
		ev = 10'h17c;
	if (raw == 32'hf014f077)
		ev = 10'h377;
	return {~toggle, ev};
endfunction

// one expected write, {address, data byte}
function automatic logic [34:0] write_ref(input io_addr_t addr, input word_t w);
	return {addr, w[7:0]};
endfunction

////////////////////////////////////////
// compare tasks
////////////////////////////////////////

task automatic check_joy(input string name, input joy_t exp, input joy_t act);
	if (act !== exp)
		stop_with_error($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
endtask

task automatic check_status(input string name, input status_t exp, input status_t act);
	if (act !== exp)
		stop_with_error($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
endtask

task automatic check_word(input string name, input word_t exp, input word_t act);
	if (act !== exp)
		stop_with_error($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
endtask

task automatic check_key(input string name, input key_event_t exp, input key_event_t act);
	if (act !== exp)
		stop_with_error($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
endtask

task automatic check_byte(input string name, input io_byte_t exp, input io_byte_t act);
	if (act !== exp)
		stop_with_error($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
endtask

task automatic check_addr(input string name, input io_addr_t exp, input io_addr_t act);
	if (act !== exp)
		stop_with_error($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
endtask

`endif

/* testbench/hps_link_tb.sv */
`timescale 1ns/1ns

module hps_link_tb import hps_link_pkg::*; ();

	localparam int N_RAND = 6;
	localparam int N_DAT  = 16;
	// strobe count over all tests in order
	localparam int N_STROBES = 22 * N_RAND + 24 + (CONF_LEN + 3) + 37 + (N_DAT + 9);
	localparam int WATCHDOG_CYCLES = N_STROBES * 6 + 1000;

	logic clk_sys, rst_n, io_strobe, io_enable, fp_enable;
	word_t io_din, io_dout, ioctl_index;
	logic [1:0] buttons;
	logic forced_scandoubler, direct_video, ioctl_download, ioctl_wr;
	joy_t joystick_0, joystick_1, joystick_2, joystick_3;
	status_t status;
	key_event_t ps2_key;
	io_addr_t ioctl_addr;
	io_byte_t ioctl_dout;

	word_t frame_words[$];
	word_t dout_q[$];
	logic [34:0] wr_q[$];
	logic [3:0] exp_cfg;
	joy_t exp_joy [4];
	status_t exp_status;
	key_event_t exp_key;

	hps_link u_hps_link (.*);

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped at first error");
	endtask

	`include "hps_link_ref.svh"

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		stop_with_error("watchdog timeout, the test sequence never finished");
	end

	////////////////////////////////////////
	// bus driver
	////////////////////////////////////////

	task automatic next_cycle(input int n);
		repeat (n) begin
			@(posedge clk_sys);
			#2;
		end
	endtask

	task automatic start_frame(input word_t cmd);
		frame_words.delete();
		frame_words.push_back(cmd);
	endtask

	task automatic add_word(input word_t w);
		frame_words.push_back(w);
	endtask

	// io_dout is captured before every strobe and once after the last
	task automatic send_frame(input logic file_side);
		dout_q.delete();
		if (file_side)
			fp_enable = 1'b1;
		else
			io_enable = 1'b1;
		next_cycle(1);
		foreach (frame_words[i]) begin
			dout_q.push_back(io_dout);
			io_din = frame_words[i];
			io_strobe = 1'b1;
			next_cycle(1);
			io_strobe = 1'b0;
			next_cycle(3);
		end
		dout_q.push_back(io_dout);
		io_enable = 1'b0;
		fp_enable = 1'b0;
		next_cycle(4);
	endtask

	function automatic uio_cmd_e joy_cmd(input int j);
		case (j)
			0: return CMD_JOY0;
			1: return CMD_JOY1;
			2: return CMD_JOY2;
			default: return CMD_JOY3;
		endcase
	endfunction

	task automatic check_uio_regs(input string name);
		check_word({name, " cfg"}, word_t'(exp_cfg),
			word_t'({direct_video, forced_scandoubler, buttons}));
		check_joy({name, " joy0"}, exp_joy[0], joystick_0);
		check_joy({name, " joy1"}, exp_joy[1], joystick_1);
		check_joy({name, " joy2"}, exp_joy[2], joystick_2);
		check_joy({name, " joy3"}, exp_joy[3], joystick_3);
	endtask

	// raw history built the way the host bytes arrive
	task automatic key_check_frame(input string name);
		logic [31:0] raw;
		logic skip;
		raw = '0;
		skip = 1'b0;
		for (int i = 1; i < frame_words.size(); i++) begin
			if (frame_words[i][15:8] == 8'hff)
				skip = 1'b1;
			else if (!skip)
				raw = {raw[23:0], frame_words[i][7:0]};
		end
		send_frame(1'b0);
		if (!skip)
			exp_key = key_ref(raw, exp_key[10]);
		check_key(name, exp_key, ps2_key);
	endtask

	// n bytes of seq with the first byte highest
	task automatic key_frame(input string name, input logic [63:0] seq, input int n);
		start_frame(CMD_KBD);
		for (int i = n - 1; i >= 0; i--)
			add_word({8'h00, seq[i * 8 +: 8]});
		key_check_frame(name);
	endtask

	always @(negedge clk_sys) begin : write_checker
		logic [34:0] exp_wr;
		if (rst_n && ioctl_wr) begin
			if (wr_q.size() == 0) begin
				stop_with_error("ioctl_wr pulsed while no write was expected");
			end else begin
				exp_wr = wr_q.pop_front();
				check_addr("download write address", exp_wr[34:8], ioctl_addr);
				check_byte("download write data", exp_wr[7:0], ioctl_dout);
			end
		end
	end

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial begin : main
		word_t w;
		word_t lo;
		io_addr_t exp_addr;
		rst_n = 1'b0;
		io_strobe = 1'b0;
		io_enable = 1'b0;
		fp_enable = 1'b0;
		io_din = '0;
		exp_cfg = '0;
		exp_status = '0;
		exp_key = '0;
		for (int j = 0; j < 4; j++)
			exp_joy[j] = '0;
		void'($urandom(32'ha08cdf69));
		next_cycle(5);
		rst_n = 1'b1;
		next_cycle(1);
		check_uio_regs("reset");
		check_status("reset status", '0, status);
		check_key("reset key", '0, ps2_key);
		check_word("reset io_dout", '0, io_dout);
		check_word("reset download", '0, word_t'({ioctl_wr, ioctl_download}));
		check_word("reset index", '0, ioctl_index);
		check_addr("reset address", '0, ioctl_addr);
		check_byte("reset data", '0, ioctl_dout);

		// configuration and joysticks
		for (int i = 0; i < N_RAND; i++) begin
			w = word_t'($urandom);
			start_frame(CMD_CFG);
			add_word(w);
			send_frame(1'b0);
			exp_cfg = cfg_ref(w);
			check_uio_regs("cfg frame");
			for (int j = 0; j < 4; j++) begin
				lo = word_t'($urandom);
				w = word_t'($urandom);
				start_frame(joy_cmd(j));
				add_word(lo);
				add_word(w);
				send_frame(1'b0);
				exp_joy[j] = joy_ref(joy_ref(exp_joy[j], lo, 1), w, 2);
				check_uio_regs("joy full frame");
				lo = word_t'($urandom);
				start_frame(joy_cmd(j));
				add_word(lo);
				send_frame(1'b0);
				exp_joy[j] = joy_ref(exp_joy[j], lo, 1);
				check_uio_regs("joy low frame");
			end
		end

		// status frames full then partial then overlong
		for (int len = 8; len <= 10; len++) begin
			start_frame(CMD_STATUS);
			for (int k = 1; k <= (len == 9 ? 3 : len); k++) begin
				w = word_t'($urandom);
				add_word(w);
				exp_status = status_ref(exp_status, w, k);
			end
			send_frame(1'b0);
			check_status($sformatf("status frame %0d", len - 8), exp_status, status);
		end

		// configuration string read-back
		start_frame(CMD_CONF_STR);
		for (int k = 0; k < CONF_LEN + 2; k++)
			add_word('0);
		send_frame(1'b0);
		for (int k = 1; k <= CONF_LEN + 2; k++)
			check_word($sformatf("conf_str byte %0d", k - 1),
				word_t'(conf_char(k - 1)), dout_q[k + 1]);
		check_word("conf_str idle", '0, io_dout);

		// keyboard events
		key_frame("key press", 64'h1c, 1);
		key_frame("key release", 64'hf01c, 2);
		key_frame("ext press", 64'he075, 2);
		key_frame("ext release", 64'he0f075, 3);
		key_frame("prtscr press", 64'he012e07c, 4);
		key_frame("prtscr release", 64'he0f07ce0f012, 6);
		key_frame("pause", 64'he11477e1f014f077, 8);
		start_frame(CMD_KBD);
		add_word(16'h001c);
		add_word(16'hff12);
		add_word(16'h0032);
		key_check_frame("skipped frame");

		// file download
		w = word_t'($urandom);
		start_frame(FIO_FILE_INDEX);
		add_word(w);
		send_frame(1'b1);
		check_word("file index", w, ioctl_index);
		start_frame(FIO_FILE_TX);
		add_word(16'h00ff);
		send_frame(1'b1);
		check_word("download start", 16'h0001, word_t'(ioctl_download));
		exp_addr = '0;
		start_frame(FIO_FILE_TX_DAT);
		for (int k = 0; k < N_DAT; k++) begin
			w = word_t'($urandom);
			add_word(w);
			wr_q.push_back(write_ref(exp_addr, w));
			exp_addr = exp_addr + 1'b1;
		end
		send_frame(1'b1);
		start_frame(FIO_FILE_TX);
		add_word(16'h0000);
		send_frame(1'b1);
		check_word("download end", '0, word_t'(ioctl_download));
		// data after the end must not write
		start_frame(FIO_FILE_TX_DAT);
		add_word(16'h00a5);
		send_frame(1'b1);

		if (wr_q.size() != 0) begin
			stop_with_error($sformatf("%0d expected writes never appeared", wr_q.size()));
		end else begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule

/* verilog.f */
+incdir+testbench
logic/hps_link_pkg.sv
logic/conf_rom.sv
logic/uio_decoder.sv
logic/ps2_key_decoder.sv
logic/file_loader.sv
logic/hps_link.sv
testbench/hps_link_tb.sv
